// File: hdl/bsr_pkg.sv
/*
  Shared sizes, types and encodings of the block-sparse accelerator.
  Blocks are 4x4 INT8, accumulators are 32-bit signed.
*/
`default_nettype none

package bsr_pkg;

    // ----------------------------------------
    // Sizes
    // ----------------------------------------
    localparam int BLK         = 4;
    localparam int DATA_W      = 8;
    localparam int ACC_W       = 32;
    localparam int MAX_BLOCKS  = 64;
    localparam int MAX_BROWS   = 16;
    localparam int MAX_BCOLS   = 16;
    localparam int CSR_ADDR_W  = 8;
    localparam int RESULT_BASE = 'h40;

    // ----------------------------------------
    // Data and index types
    // ----------------------------------------
    typedef logic signed [DATA_W-1:0] data_t;
    typedef logic signed [ACC_W-1:0]  acc_t;
    // Four activations, element j at bits 8j upward
    typedef logic [BLK*DATA_W-1:0]     act_word_t;
    // Block row i at bits 32i upward
    typedef logic [BLK*BLK*DATA_W-1:0] wgt_block_t;
    typedef logic [5:0] blk_idx_t;
    // Holds 0..64 inclusive
    typedef logic [6:0] ptr_t;
    typedef logic [4:0] brow_t;
    typedef logic [3:0] bcol_t;
    typedef logic [5:0] res_idx_t;

    // ----------------------------------------
    // Encodings
    // ----------------------------------------
    typedef enum logic [1:0] {ROW_PTR, COL_IDX, WGT, ACT} mem_sel_t;

    typedef enum logic [CSR_ADDR_W-1:0] {
        CTRL      = 8'h00,
        STATUS    = 8'h01,
        NUM_BROWS = 8'h02
    } csr_reg_t;

    typedef enum logic [2:0] {
        IDLE, RD_PTR_LO, RD_PTR_HI, RD_COL, RD_DATA, MAC, STORE
    } sched_state_t;

endpackage

`default_nettype wire

// File: hdl/bsr_csr.sv
/*
  Register bank on a plain strobe bus, read data valid one cycle after csr_ren.
  CTRL is write-only. Result window holds 64 entries from RESULT_BASE.
*/
`timescale 1ns/100ps
`default_nettype none

module bsr_csr (
    input  wire logic                                clk,
    input  wire logic                                rst,
    input  wire logic                                csr_wen,
    input  wire logic                                csr_ren,
    input  wire logic [bsr_pkg::CSR_ADDR_W-1:0]      csr_addr,
    input  wire logic [31:0]                         csr_wdata,
    output logic      [31:0]                         csr_rdata,
    input  wire logic                                busy,
    input  wire logic                                done,
    output logic                                     start,
    output logic                                     abort,
    output bsr_pkg::brow_t                           num_brows,
    output bsr_pkg::res_idx_t                        res_raddr,
    input  wire bsr_pkg::acc_t                       res_rdata
);

    logic                            done_sticky;
    logic [bsr_pkg::CSR_ADDR_W-1:0]  res_off;
    logic                            in_window;

    // Offset into the result window
    assign res_off   = csr_addr - bsr_pkg::CSR_ADDR_W'(bsr_pkg::RESULT_BASE);
    assign res_raddr = res_off[$bits(bsr_pkg::res_idx_t)-1:0];
    assign in_window = (csr_addr >= bsr_pkg::RESULT_BASE) &&
                       (res_off < bsr_pkg::BLK * bsr_pkg::MAX_BROWS);

    // ----------------------------------------
    // Write side
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            start       <= 1'b0;
            abort       <= 1'b0;
            num_brows   <= '0;
            done_sticky <= 1'b0;
        end else begin
            // One-cycle pulses from CTRL bits 0 and 1
            start <= csr_wen && (csr_addr == bsr_pkg::CTRL) && csr_wdata[0];
            abort <= csr_wen && (csr_addr == bsr_pkg::CTRL) && csr_wdata[1];
            if (csr_wen && (csr_addr == bsr_pkg::NUM_BROWS))
                num_brows <= csr_wdata[$bits(bsr_pkg::brow_t)-1:0];
            // Start wins over a stale done
            if (start)
                done_sticky <= 1'b0;
            else if (done)
                done_sticky <= 1'b1;
        end
    end

    // ----------------------------------------
    // Read side
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            csr_rdata <= '0;
        end else if (csr_ren) begin
            if (in_window) begin
                csr_rdata <= res_rdata;
            end else begin
                case (csr_addr)
                    // Pending start already counts as busy
                    bsr_pkg::STATUS:    csr_rdata <= {30'b0, done_sticky & ~start, busy | start};
                    bsr_pkg::NUM_BROWS: csr_rdata <= 32'(num_brows);
                    default:            csr_rdata <= '0;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/bsr_mem.sv
/*
  BSR tables and activations, written only through the load port while idle.
  All read ports are registered and hold their data while the enable is low.
*/
`timescale 1ns/100ps
`default_nettype none

module bsr_mem (
    input  wire logic                clk,
    // Load port
    input  wire logic                load_we,
    input  wire bsr_pkg::mem_sel_t   load_sel,
    input  wire logic [7:0]          load_addr,
    input  wire logic [31:0]         load_data,
    // Read ports
    input  wire logic                ptr_rd_en,
    input  wire bsr_pkg::brow_t      ptr_rd_addr,
    output bsr_pkg::ptr_t            ptr_rd_data,
    input  wire logic                col_rd_en,
    input  wire bsr_pkg::blk_idx_t   col_rd_addr,
    output bsr_pkg::bcol_t           col_rd_data,
    input  wire logic                blk_rd_en,
    input  wire bsr_pkg::blk_idx_t   blk_rd_addr,
    output bsr_pkg::wgt_block_t      blk_rd_data,
    input  wire logic                act_rd_en,
    input  wire bsr_pkg::bcol_t      act_rd_addr,
    output bsr_pkg::act_word_t       act_rd_data
);

    localparam int WORD_W = $bits(bsr_pkg::act_word_t);

    // Row pointers need one entry past the last block row
    bsr_pkg::ptr_t     ptr_mem [bsr_pkg::MAX_BROWS+1];
    bsr_pkg::bcol_t    col_mem [bsr_pkg::MAX_BLOCKS];
    bsr_pkg::act_word_t act_mem [bsr_pkg::MAX_BCOLS];
    // One bank per block row so a block reads in one cycle
    bsr_pkg::act_word_t wgt_mem [bsr_pkg::BLK][bsr_pkg::MAX_BLOCKS];

    // ----------------------------------------
    // Metadata and activations
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (load_we && load_sel == bsr_pkg::ROW_PTR)
            ptr_mem[load_addr[$bits(bsr_pkg::brow_t)-1:0]] <=
                load_data[$bits(bsr_pkg::ptr_t)-1:0];
        if (load_we && load_sel == bsr_pkg::COL_IDX)
            col_mem[load_addr[$bits(bsr_pkg::blk_idx_t)-1:0]] <=
                load_data[$bits(bsr_pkg::bcol_t)-1:0];
        if (load_we && load_sel == bsr_pkg::ACT)
            act_mem[load_addr[$bits(bsr_pkg::bcol_t)-1:0]] <= load_data;

        if (ptr_rd_en)
            ptr_rd_data <= ptr_mem[ptr_rd_addr];
        if (col_rd_en)
            col_rd_data <= col_mem[col_rd_addr];
        if (act_rd_en)
            act_rd_data <= act_mem[act_rd_addr];
    end

    // ----------------------------------------
    // Weight banks
    // ----------------------------------------
    // Address bits 7:2 pick the block, bits 1:0 the bank
    always_ff @(posedge clk) begin
        for (int b = 0; b < bsr_pkg::BLK; b++) begin
            if (load_we && load_sel == bsr_pkg::WGT && load_addr[1:0] == b)
                wgt_mem[b][load_addr[7:2]] <= load_data;
            if (blk_rd_en)
                blk_rd_data[b*WORD_W +: WORD_W] <= wgt_mem[b][blk_rd_addr];
        end
    end

endmodule

`default_nettype wire

// File: hdl/bsr_scheduler.sv
/*
  Walks BSR rows 0..num_brows-1, num_brows must not exceed MAX_BROWS.
  A start with zero rows only pulses done. Abort returns to idle without done.
*/
`timescale 1ns/100ps
`default_nettype none

module bsr_scheduler (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                start,
    input  wire logic                abort,
    input  wire bsr_pkg::brow_t      num_brows,
    output logic                     busy,
    output logic                     done,
    // Memory reads
    output logic                     ptr_rd_en,
    output bsr_pkg::brow_t           ptr_rd_addr,
    input  wire bsr_pkg::ptr_t       ptr_rd_data,
    output logic                     col_rd_en,
    output bsr_pkg::blk_idx_t        col_rd_addr,
    input  wire bsr_pkg::bcol_t      col_rd_data,
    output logic                     blk_rd_en,
    output bsr_pkg::blk_idx_t        blk_rd_addr,
    output logic                     act_rd_en,
    output bsr_pkg::bcol_t           act_rd_addr,
    // MAC control
    output logic                     mac_clear,
    output logic                     mac_en,
    output logic                     mac_store,
    output bsr_pkg::brow_t           store_brow
);

    bsr_pkg::sched_state_t state;
    bsr_pkg::brow_t        brow;
    bsr_pkg::brow_t        brow_nxt;
    bsr_pkg::ptr_t         k;
    bsr_pkg::ptr_t         k_nxt;

    assign brow_nxt = brow + 1'b1;
    assign k_nxt    = k + 1'b1;

    // ----------------------------------------
    // Decoded outputs
    // ----------------------------------------
    assign busy = (state != bsr_pkg::IDLE);

    // LO reads row_ptr[r], HI reads row_ptr[r+1]
    assign ptr_rd_en   = (state == bsr_pkg::RD_PTR_LO) || (state == bsr_pkg::RD_PTR_HI);
    assign ptr_rd_addr = (state == bsr_pkg::RD_PTR_HI) ? brow_nxt : brow;

    // Pointer output keeps row_ptr[r+1] as the row end until the next row
    assign col_rd_en   = (state == bsr_pkg::RD_COL) && (k != ptr_rd_data);
    assign col_rd_addr = k[$bits(bsr_pkg::blk_idx_t)-1:0];

    assign blk_rd_en   = (state == bsr_pkg::RD_DATA);
    assign blk_rd_addr = k[$bits(bsr_pkg::blk_idx_t)-1:0];
    assign act_rd_en   = (state == bsr_pkg::RD_DATA);
    assign act_rd_addr = col_rd_data;

    assign mac_clear  = (state == bsr_pkg::RD_PTR_LO);
    assign mac_en     = (state == bsr_pkg::MAC);
    assign mac_store  = (state == bsr_pkg::STORE);
    assign store_brow = brow;

    // ----------------------------------------
    // FSM
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= bsr_pkg::IDLE;
            brow  <= '0;
            k     <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (abort && state != bsr_pkg::IDLE) begin
                state <= bsr_pkg::IDLE;
            end else begin
                case (state)
                    bsr_pkg::IDLE: begin
                        brow <= '0;
                        if (start && num_brows == '0)
                            done <= 1'b1;
                        else if (start)
                            state <= bsr_pkg::RD_PTR_LO;
                    end
                    bsr_pkg::RD_PTR_LO: state <= bsr_pkg::RD_PTR_HI;
                    bsr_pkg::RD_PTR_HI: begin
                        // First block index of the row
                        k     <= ptr_rd_data;
                        state <= bsr_pkg::RD_COL;
                    end
                    bsr_pkg::RD_COL: begin
                        // Empty row skips straight to the store
                        state <= (k == ptr_rd_data) ? bsr_pkg::STORE : bsr_pkg::RD_DATA;
                    end
                    bsr_pkg::RD_DATA: state <= bsr_pkg::MAC;
                    bsr_pkg::MAC: begin
                        k     <= k_nxt;
                        state <= (k_nxt == ptr_rd_data) ? bsr_pkg::STORE : bsr_pkg::RD_COL;
                    end
                    bsr_pkg::STORE: begin
                        brow <= brow_nxt;
                        if (brow_nxt == num_brows) begin
                            state <= bsr_pkg::IDLE;
                            done  <= 1'b1;
                        end else begin
                            state <= bsr_pkg::RD_PTR_LO;
                        end
                    end
                    default: state <= bsr_pkg::IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/bsr_block_mac.sv
/*
  Four-lane block MAC, lane i accumulates row i of each 4x4 block times x.
  Result file holds 4 entries per block row and resets to zero.
*/
`timescale 1ns/100ps
`default_nettype none

module bsr_block_mac (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  mac_clear,
    input  wire logic                  mac_en,
    input  wire logic                  mac_store,
    input  wire bsr_pkg::brow_t        store_brow,
    input  wire bsr_pkg::wgt_block_t   blk_rd_data,
    input  wire bsr_pkg::act_word_t    act_rd_data,
    input  wire bsr_pkg::res_idx_t     res_raddr,
    output bsr_pkg::acc_t              res_rdata
);

    localparam int BLK    = bsr_pkg::BLK;
    localparam int DW     = bsr_pkg::DATA_W;
    localparam int N_RES  = BLK * bsr_pkg::MAX_BROWS;

    bsr_pkg::acc_t lane [BLK];
    bsr_pkg::acc_t dot  [BLK];
    bsr_pkg::acc_t res  [N_RES];

    // ----------------------------------------
    // Block row dot products
    // ----------------------------------------
    // Signed 8x8 products, sign extended into the 32-bit sum
    always_comb begin
        for (int i = 0; i < BLK; i++) begin
            dot[i] = '0;
            for (int j = 0; j < BLK; j++) begin
                dot[i] = dot[i] +
                    bsr_pkg::data_t'(blk_rd_data[(i*BLK + j)*DW +: DW]) *
                    bsr_pkg::data_t'(act_rd_data[j*DW +: DW]);
            end
        end
    end

    // ----------------------------------------
    // Lanes and result file
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < BLK; i++)
                lane[i] <= '0;
            for (int r = 0; r < N_RES; r++)
                res[r] <= '0;
        end else begin
            // Clear at row start, accumulate once per block
            for (int i = 0; i < BLK; i++) begin
                if (mac_clear)
                    lane[i] <= '0;
                else if (mac_en)
                    lane[i] <= lane[i] + dot[i];
            end
            // Row r lands at entries 4r..4r+3
            if (mac_store) begin
                for (int i = 0; i < BLK; i++)
                    res[bsr_pkg::res_idx_t'(store_brow * BLK + i)] <= lane[i];
            end
        end
    end

    assign res_rdata = res[res_raddr];

endmodule

`default_nettype wire

// File: hdl/bsr_accel_top.sv
/*
  Block-sparse y = W*x engine with register bus and direct load port.
  Memories must only be loaded while busy is low.
*/
`timescale 1ns/100ps
`default_nettype none

module bsr_accel_top (
    input  wire logic                            clk,
    input  wire logic                            rst,
    // Register bus
    input  wire logic                            csr_wen,
    input  wire logic                            csr_ren,
    input  wire logic [bsr_pkg::CSR_ADDR_W-1:0]  csr_addr,
    input  wire logic [31:0]                     csr_wdata,
    output logic      [31:0]                     csr_rdata,
    // Load port
    input  wire logic                            load_we,
    input  wire bsr_pkg::mem_sel_t               load_sel,
    input  wire logic [7:0]                      load_addr,
    input  wire logic [31:0]                     load_data,
    // Status
    output logic                                 busy,
    output logic                                 done
);

    // ----------------------------------------
    // Internal nets
    // ----------------------------------------
    logic                  start, abort;
    bsr_pkg::brow_t        num_brows;
    bsr_pkg::res_idx_t     res_raddr;
    bsr_pkg::acc_t         res_rdata;
    logic                  ptr_rd_en, col_rd_en, blk_rd_en, act_rd_en;
    bsr_pkg::brow_t        ptr_rd_addr;
    bsr_pkg::blk_idx_t     col_rd_addr, blk_rd_addr;
    bsr_pkg::bcol_t        act_rd_addr;
    bsr_pkg::ptr_t         ptr_rd_data;
    bsr_pkg::bcol_t        col_rd_data;
    bsr_pkg::wgt_block_t   blk_rd_data;
    bsr_pkg::act_word_t    act_rd_data;
    logic                  mac_clear, mac_en, mac_store;
    bsr_pkg::brow_t        store_brow;

    // Control and status registers
    bsr_csr u_csr (
        .clk, .rst, .csr_wen, .csr_ren, .csr_addr, .csr_wdata, .csr_rdata,
        .busy, .done, .start, .abort, .num_brows, .res_raddr, .res_rdata
    );

    // Row and block traversal
    bsr_scheduler u_sched (
        .clk, .rst, .start, .abort, .num_brows, .busy, .done,
        .ptr_rd_en, .ptr_rd_addr, .ptr_rd_data,
        .col_rd_en, .col_rd_addr, .col_rd_data,
        .blk_rd_en, .blk_rd_addr, .act_rd_en, .act_rd_addr,
        .mac_clear, .mac_en, .mac_store, .store_brow
    );

    // BSR tables, weights and activations
    bsr_mem u_mem (
        .clk, .load_we, .load_sel, .load_addr, .load_data,
        .ptr_rd_en, .ptr_rd_addr, .ptr_rd_data,
        .col_rd_en, .col_rd_addr, .col_rd_data,
        .blk_rd_en, .blk_rd_addr, .blk_rd_data,
        .act_rd_en, .act_rd_addr, .act_rd_data
    );

    // Block multiply-accumulate and results
    bsr_block_mac u_mac (
        .clk, .rst, .mac_clear, .mac_en, .mac_store, .store_brow,
        .blk_rd_data, .act_rd_data, .res_raddr, .res_rdata
    );

endmodule

`default_nettype wire

// File: tb/bsr_accel_assert.sv
/*
  Protocol checks on busy and done, bound into the accelerator top level.
*/
`timescale 1ns/100ps
`default_nettype none

module bsr_accel_assert (
    input wire logic clk,
    input wire logic rst,
    input wire logic busy,
    input wire logic done
);

    // Running count of assertion failures
    int fail_count = 0;

    // Done is a single-cycle pulse
    done_single_cycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            fail_count++;
            $error("done held high for two cycles");
        end

    // Busy drops in the cycle of done
    done_not_busy: assert property (@(posedge clk) disable iff (rst) done |-> !busy)
        else begin
            fail_count++;
            $error("busy high while done pulses");
        end

    // Second reset cycle onward, state already cleared
    quiet_in_reset: assert property (@(posedge clk) (rst && $past(rst)) |-> (!busy && !done))
        else begin
            fail_count++;
            $error("busy or done active during reset");
        end

endmodule

`default_nettype wire

// File: tb/tb_bsr_accel.sv
/*
  Directed testbench for the block-sparse accelerator, stops at the first error.
  Reference model is kept in plain arrays, results read back over the register bus.
*/
`timescale 1ns/100ps
`default_nettype none

module tb_bsr_accel;

    localparam int BLK = bsr_pkg::BLK;
    localparam int TIMEOUT_CYCLES = 1000;

    logic               clk;
    logic               rst;
    logic               csr_wen;
    logic               csr_ren;
    logic [7:0]         csr_addr;
    logic [31:0]        csr_wdata;
    logic [31:0]        csr_rdata;
    logic               load_we;
    bsr_pkg::mem_sel_t  load_sel;
    logic [7:0]         load_addr;
    logic [31:0]        load_data;
    logic               busy;
    logic               done;

    // Reference matrix in BSR form and activation vector
    int              n_brows;
    int              n_bcols;
    int              rp [bsr_pkg::MAX_BROWS+1];
    int              ci [bsr_pkg::MAX_BLOCKS];
    bsr_pkg::data_t  w  [bsr_pkg::MAX_BLOCKS][BLK][BLK];
    bsr_pkg::data_t  x  [bsr_pkg::MAX_BCOLS*BLK];

    logic [31:0]     rng_state = 32'd64107;
    int              done_count;

    bsr_accel_top uut (
        .clk, .rst, .csr_wen, .csr_ren, .csr_addr, .csr_wdata, .csr_rdata,
        .load_we, .load_sel, .load_addr, .load_data, .busy, .done
    );

    bind bsr_accel_top bsr_accel_assert u_assert (.clk, .rst, .busy, .done);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Done pulses since reset
    always @(posedge clk) begin
        if (rst)
            done_count <= 0;
        else if (done)
            done_count <= done_count + 1;
    end

    // Bound assertion failures end the run at once
    always @(negedge clk) begin
        if (uut.u_assert.fail_count != 0)
            report_failure("a concurrent assertion failed during the run");
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    function automatic logic [31:0] xorshift32();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_acc(input string name, input bsr_pkg::acc_t actual,
                             input bsr_pkg::acc_t expected);
        if (actual !== expected)
            report_failure($sformatf("mismatch %s: expected 0x%08h, actual 0x%08h",
                                     name, expected, actual));
    endtask

    task automatic check_status(input logic [31:0] actual, input logic [31:0] expected);
        if (actual !== expected)
            report_failure($sformatf("mismatch STATUS: expected 0x%08h, actual 0x%08h",
                                     expected, actual));
    endtask

    // Single-cycle strobes, launched on the rising edge
    task automatic load_word(input bsr_pkg::mem_sel_t sel, input logic [7:0] addr,
                             input logic [31:0] data);
        @(posedge clk);
        load_we   <= 1'b1;
        load_sel  <= sel;
        load_addr <= addr;
        load_data <= data;
        @(posedge clk);
        load_we   <= 1'b0;
    endtask

    task automatic csr_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        csr_wen   <= 1'b1;
        csr_addr  <= addr;
        csr_wdata <= data;
        @(posedge clk);
        csr_wen   <= 1'b0;
    endtask

    // Read data is registered, sampled half a cycle later
    task automatic csr_read(input logic [7:0] addr, output logic [31:0] data);
        @(posedge clk);
        csr_ren  <= 1'b1;
        csr_addr <= addr;
        @(posedge clk);
        csr_ren  <= 1'b0;
        @(negedge clk);
        data = csr_rdata;
    endtask

    task automatic load_acts();
        logic [31:0] word;
        for (int c = 0; c < n_bcols; c++) begin
            // Element j at bits 8j upward
            for (int j = 0; j < BLK; j++)
                word[8*j +: 8] = x[BLK*c + j];
            load_word(bsr_pkg::ACT, 8'(c), word);
        end
    endtask

    task automatic load_matrix();
        logic [31:0] word;
        for (int r = 0; r <= n_brows; r++)
            load_word(bsr_pkg::ROW_PTR, 8'(r), 32'(rp[r]));
        for (int k = 0; k < rp[n_brows]; k++) begin
            load_word(bsr_pkg::COL_IDX, 8'(k), 32'(ci[k]));
            // One word per block row, bank picked by the low address bits
            for (int i = 0; i < BLK; i++) begin
                for (int j = 0; j < BLK; j++)
                    word[8*j +: 8] = w[k][i][j];
                load_word(bsr_pkg::WGT, 8'(BLK*k + i), word);
            end
        end
        load_acts();
        csr_write(bsr_pkg::NUM_BROWS, 32'(n_brows));
    endtask

    task automatic random_acts();
        for (int e = 0; e < BLK*n_bcols; e++)
            x[e] = bsr_pkg::data_t'(xorshift32());
    endtask

    // Dense fills every block, otherwise each block kept at random
    task automatic build_random_matrix(input int nbr, input int nbc, input bit dense);
        int nb;
        n_brows = nbr;
        n_bcols = nbc;
        nb = 0;
        for (int r = 0; r < nbr; r++) begin
            rp[r] = nb;
            for (int c = 0; c < nbc; c++) begin
                if (dense || (xorshift32() & 32'h100) != 0) begin
                    ci[nb] = c;
                    for (int i = 0; i < BLK; i++)
                        for (int j = 0; j < BLK; j++)
                            w[nb][i][j] = bsr_pkg::data_t'(xorshift32());
                    nb++;
                end
            end
        end
        rp[nbr] = nb;
        random_acts();
    endtask

    // y[4r+i] from the BSR rule, sign extended products
    function automatic bsr_pkg::acc_t expected_result(input int idx);
        bsr_pkg::acc_t sum;
        int r;
        int i;
        r = idx / BLK;
        i = idx % BLK;
        sum = '0;
        for (int k = rp[r]; k < rp[r+1]; k++)
            for (int j = 0; j < BLK; j++)
                sum += bsr_pkg::acc_t'(w[k][i][j]) * bsr_pkg::acc_t'(x[BLK*ci[k] + j]);
        return sum;
    endfunction

    task automatic check_results();
        logic [31:0] data;
        for (int idx = 0; idx < BLK*n_brows; idx++) begin
            csr_read(8'(bsr_pkg::RESULT_BASE + idx), data);
            check_acc($sformatf("result[%0d]", idx), bsr_pkg::acc_t'(data),
                      expected_result(idx));
        end
    endtask

    // ----------------------------------------
    // Run control
    // ----------------------------------------
    task automatic start_run();
        csr_write(bsr_pkg::CTRL, 32'h1);
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES)
                report_failure("timeout: done never pulsed");
        end while (done !== 1'b1);
    endtask

    task automatic wait_busy_low();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES)
                report_failure("timeout: busy never went low");
        end while (busy !== 1'b0);
    endtask

    task automatic run_and_wait();
        start_run();
        wait_done();
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic test_diagonal();
        logic [31:0] status;
        n_brows = 2;
        n_bcols = 2;
        for (int r = 0; r <= 2; r++)
            rp[r] = r;
        for (int k = 0; k < 2; k++) begin
            ci[k] = k;
            for (int i = 0; i < BLK; i++)
                for (int j = 0; j < BLK; j++)
                    w[k][i][j] = bsr_pkg::data_t'(16*k + 4*i + j + 1);
        end
        for (int e = 0; e < 8; e++)
            x[e] = bsr_pkg::data_t'(3*e - 10);
        load_matrix();
        run_and_wait();
        check_results();
        csr_read(bsr_pkg::STATUS, status);
        check_status(status, 32'h2);
    endtask

    // Rows of 2, 0 and 3 blocks, values spread over the full INT8 range
    task automatic test_multi_block();
        int rows [4] = '{0, 2, 2, 5};
        int cols [5] = '{0, 2, 0, 1, 3};
        n_brows = 3;
        n_bcols = 4;
        for (int r = 0; r < 4; r++)
            rp[r] = rows[r];
        for (int k = 0; k < 5; k++) begin
            ci[k] = cols[k];
            for (int i = 0; i < BLK; i++)
                for (int j = 0; j < BLK; j++)
                    w[k][i][j] = bsr_pkg::data_t'(((16*k + 4*i + j) * 37) % 256 - 128);
        end
        for (int e = 0; e < 16; e++)
            x[e] = bsr_pkg::data_t'((e * 29) % 256 - 128);
        load_matrix();
        run_and_wait();
        check_results();
    endtask

    task automatic test_random();
        build_random_matrix(4, 4, 1'b0);
        load_matrix();
        run_and_wait();
        check_results();
    endtask

    // Same matrix, new activations
    task automatic test_restart();
        logic [31:0] status;
        random_acts();
        load_acts();
        start_run();
        csr_read(bsr_pkg::STATUS, status);
        check_status(status, 32'h1);
        wait_done();
        check_results();
    endtask

    // Full 16x4 dense run, cut short
    task automatic test_abort();
        logic [31:0] status;
        int done_before;
        build_random_matrix(16, 4, 1'b1);
        load_matrix();
        done_before = done_count;
        start_run();
        repeat (20) @(negedge clk);
        if (busy !== 1'b1)
            report_failure("run ended before the abort was written");
        csr_write(bsr_pkg::CTRL, 32'h2);
        wait_busy_low();
        repeat (8) @(negedge clk);
        if (done_count != done_before)
            report_failure("done pulsed during an aborted run");
        csr_read(bsr_pkg::STATUS, status);
        check_status(status, 32'h0);
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        rst       <= 1'b1;
        csr_wen   <= 1'b0;
        csr_ren   <= 1'b0;
        csr_addr  <= '0;
        csr_wdata <= '0;
        load_we   <= 1'b0;
        load_sel  <= bsr_pkg::ROW_PTR;
        load_addr <= '0;
        load_data <= '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        test_diagonal();
        test_multi_block();
        test_random();
        test_restart();
        test_abort();

        @(negedge clk);
        if (uut.u_assert.fail_count != 0) begin
            report_failure("a concurrent assertion failed during the run");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: list.f
hdl/bsr_pkg.sv
hdl/bsr_csr.sv
hdl/bsr_mem.sv
hdl/bsr_scheduler.sv
hdl/bsr_block_mac.sv
hdl/bsr_accel_top.sv
tb/bsr_accel_assert.sv
tb/tb_bsr_accel.sv

// File: Bender.yml
package:
  name: bsr_accel

sources:
  - hdl/bsr_pkg.sv
  - hdl/bsr_csr.sv
  - hdl/bsr_mem.sv
  - hdl/bsr_scheduler.sv
  - hdl/bsr_block_mac.sv
  - hdl/bsr_accel_top.sv
  - target: test
    files:
      - tb/bsr_accel_assert.sv
      - tb/tb_bsr_accel.sv
